/* design/colour_pkg.sv */
package colour_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Colour word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int colour_bits = 12;             // {red, green, blue}
    localparam int nibble_bits = 4;              // One component
    localparam int red_lsb     = 2 * nibble_bits;
    localparam int green_lsb   = nibble_bits;
    localparam int blue_lsb    = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Palette geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_entries = 32;             // Secondary palette depth
    localparam int index_bits  = 5;

    // Primary lookups only see the lower 16 entries
    localparam logic [index_bits-1:0] primary_index_mask = index_bits'(15);

    ////////////////////////////////////////////////////////////////////////////
    // MRER mode codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int mode_bits          = 5;
    localparam int num_enhanced_codes = 5;

    // Any of these in the MRER mode field selects enhanced mode
    localparam logic [mode_bits-1:0] mode_enhanced_codes [num_enhanced_codes] = '{
        5'h01,                                   // Enhanced video
        5'h02,                                   // Sprite
        5'h03,                                   // Video plus sprite
        5'h04,                                   // Audio enhanced
        5'h0C                                    // Plus with enhanced features
    };

endpackage

/* design/asic_map_pkg.sv */
package asic_map_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // CPU bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int addr_bits = 16;
    localparam int data_bits = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Primary palette window, two bytes per entry
    localparam logic [addr_bits-1:0] primary_base      = 16'h6400;
    localparam int                   primary_span_bits = 6;     // 64 bytes

    // Secondary palette port
    localparam logic [addr_bits-1:0] sec_pointer_addr = 16'h7F88;  // Pointer load
    localparam logic [addr_bits-1:0] sec_rg_addr      = 16'h7F89;  // Red/green latch
    localparam logic [addr_bits-1:0] sec_b_addr       = 16'h7F8A;  // Blue and commit

    localparam logic [addr_bits-1:0] mrer_addr = 16'h7F8C;      // Mode and ROM enable

    ////////////////////////////////////////////////////////////////////////////
    // CPU data byte views
    ////////////////////////////////////////////////////////////////////////////

    // Red/green latch byte
    typedef struct packed {
        logic [colour_pkg::nibble_bits-1:0] red;
        logic [colour_pkg::nibble_bits-1:0] green;
    } rg_nibbles_t;

    // MRER byte, only taken when sel is clear
    typedef struct packed {
        logic                             plus;  // Plus features on
        logic                             rom;   // ROM enable
        logic                             sel;   // Set means not MRER
        logic [colour_pkg::mode_bits-1:0] mode;
    } mrer_fields_t;

    typedef union packed {
        rg_nibbles_t  rg_nibbles;
        mrer_fields_t mrer_fields;
    } asic_byte_u;

endpackage

/* design/asic_reg_decoder.sv */
module asic_reg_decoder (
    input  logic                                 clk_sys,
    input  logic                                 reset,
    input  logic [asic_map_pkg::addr_bits-1:0]   cpu_addr,
    input  logic [asic_map_pkg::data_bits-1:0]   cpu_data,
    input  logic                                 cpu_wr,
    input  logic                                 plus_mode,
    output logic [colour_pkg::index_bits-1:0]    wr_index,
    output logic                                 prim_g_we,
    output logic                                 prim_rb_we,
    output logic                                 sec_we,
    output logic [colour_pkg::colour_bits-1:0]   sec_colour,
    output logic [asic_map_pkg::data_bits-1:0]   wr_byte,
    output logic                                 plus_active,
    output logic                                 enhanced_active
);

    asic_map_pkg::asic_byte_u cpu_byte;          // Data byte, two decodings
    asic_map_pkg::asic_byte_u rg_latch;          // Held red/green for commit

    logic [colour_pkg::index_bits-1:0] pointer;  // Secondary write pointer
    logic [colour_pkg::mode_bits-1:0]  mrer_mode;
    logic                              mrer_plus;
    logic                              mode_is_enhanced;

    logic hit_primary;
    logic hit_pointer;
    logic hit_rg;
    logic hit_blue;
    logic hit_mrer;

    assign cpu_byte = cpu_data;

    ////////////////////////////////////////////////////////////////////////////
    // Address match
    ////////////////////////////////////////////////////////////////////////////

    assign hit_primary = cpu_addr[asic_map_pkg::addr_bits-1:asic_map_pkg::primary_span_bits]
        == asic_map_pkg::primary_base[asic_map_pkg::addr_bits-1:asic_map_pkg::primary_span_bits];
    assign hit_pointer = cpu_addr == asic_map_pkg::sec_pointer_addr;
    assign hit_rg      = cpu_addr == asic_map_pkg::sec_rg_addr;
    assign hit_blue    = cpu_addr == asic_map_pkg::sec_b_addr;
    assign hit_mrer    = cpu_addr == asic_map_pkg::mrer_addr;

    // Even byte is green, odd byte is red/blue
    assign prim_g_we  = cpu_wr & hit_primary & ~cpu_addr[0];
    assign prim_rb_we = cpu_wr & hit_primary & cpu_addr[0];
    assign sec_we     = cpu_wr & hit_blue;   // Blue write commits the entry

    // Primary takes its index from the address, secondary from the pointer
    assign wr_index = hit_primary ? cpu_addr[asic_map_pkg::primary_span_bits-1:1] : pointer;

    // Blue arrives in the upper nibble of the commit byte
    assign sec_colour = {rg_latch.rg_nibbles.red, rg_latch.rg_nibbles.green,
                         cpu_byte.rg_nibbles.red};
    assign wr_byte    = cpu_data;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer, latch and MRER state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pointer   <= '0;
            rg_latch  <= '0;
            mrer_mode <= '0;
            mrer_plus <= 1'b0;
        end else if (cpu_wr) begin
            if (hit_pointer)
                pointer <= cpu_data[colour_pkg::index_bits-1:0];
            if (hit_rg)
                rg_latch <= cpu_byte;
            if (hit_blue)
                pointer <= pointer + 1'b1;       // Auto-increment, wraps at 32
            if (hit_mrer && !cpu_byte.mrer_fields.sel) begin
                mrer_mode <= cpu_byte.mrer_fields.mode;
                mrer_plus <= cpu_byte.mrer_fields.plus;
            end
        end
    end

    // Mode code lookup
    always_comb begin
        mode_is_enhanced = 1'b0;
        for (int i = 0; i < colour_pkg::num_enhanced_codes; i++) begin
            if (mrer_mode == colour_pkg::mode_enhanced_codes[i])
                mode_is_enhanced = 1'b1;
        end
    end

    assign plus_active     = plus_mode | mrer_plus;
    assign enhanced_active = plus_mode | mode_is_enhanced;  // Plus input forces enhanced

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // One palette write broadcast per cycle to all entries
    assert property (@(posedge clk_sys) disable iff (reset)
        $onehot0({prim_g_we, prim_rb_we, sec_we}))
        else $error("more than one palette write strobe");

endmodule

/* design/palette_entry.sv */
module palette_entry #(
    parameter int entry_index = 0                // Position in the palette
) (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic [colour_pkg::index_bits-1:0]   wr_index,
    input  logic                                prim_g_we,
    input  logic                                prim_rb_we,
    input  logic                                sec_we,
    input  logic [colour_pkg::colour_bits-1:0]  sec_colour,
    input  logic [asic_map_pkg::data_bits-1:0]  wr_byte,
    output logic [colour_pkg::colour_bits-1:0]  primary_colour,
    output logic [colour_pkg::colour_bits-1:0]  secondary_colour
);

    logic selected;                              // Broadcast write targets us

    assign selected = wr_index == entry_index[colour_pkg::index_bits-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Colour registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            primary_colour   <= '0;
            secondary_colour <= '0;
        end else if (selected) begin
            // Primary arrives a nibble pair at a time
            if (prim_g_we)
                primary_colour[colour_pkg::green_lsb +: colour_pkg::nibble_bits]
                    <= wr_byte[0 +: colour_pkg::nibble_bits];
            if (prim_rb_we) begin
                primary_colour[colour_pkg::red_lsb +: colour_pkg::nibble_bits]
                    <= wr_byte[colour_pkg::nibble_bits +: colour_pkg::nibble_bits];
                primary_colour[colour_pkg::blue_lsb +: colour_pkg::nibble_bits]
                    <= wr_byte[0 +: colour_pkg::nibble_bits];
            end
            if (sec_we)
                secondary_colour <= sec_colour;  // Whole word from latch plus blue
        end
    end

endmodule

/* design/pixel_colour_mux.sv */
module pixel_colour_mux (
    input  logic                                                    clk_sys,
    input  logic                                                    reset,
    input  logic [colour_pkg::index_bits-1:0]                       pixel_index,
    input  logic                                                    sprite_active,
    input  logic [colour_pkg::index_bits-1:0]                       sprite_pixel,
    input  logic                                                    plus_active,
    input  logic                                                    enhanced_active,
    input  logic [colour_pkg::num_entries*colour_pkg::colour_bits-1:0] primary_colours,
    input  logic [colour_pkg::num_entries*colour_pkg::colour_bits-1:0] secondary_colours,
    output logic [colour_pkg::nibble_bits-1:0]                      r_out,
    output logic [colour_pkg::nibble_bits-1:0]                      g_out,
    output logic [colour_pkg::nibble_bits-1:0]                      b_out
);

    logic [colour_pkg::index_bits-1:0]  eff_index;     // Sprite overrides background
    logic [colour_pkg::index_bits-1:0]  masked_index;  // Primary only has 16
    logic [colour_pkg::colour_bits-1:0] sec_colour;
    logic [colour_pkg::colour_bits-1:0] prim_colour;
    logic [colour_pkg::colour_bits-1:0] sel_colour;

    assign eff_index    = sprite_active ? sprite_pixel : pixel_index;
    assign masked_index = eff_index & colour_pkg::primary_index_mask;

    assign sec_colour  = secondary_colours[eff_index * colour_pkg::colour_bits
                                           +: colour_pkg::colour_bits];
    assign prim_colour = primary_colours[masked_index * colour_pkg::colour_bits
                                         +: colour_pkg::colour_bits];

    // Plus beats enhanced beats standard
    always_comb begin
        if (plus_active)
            sel_colour = sec_colour;
        else if (enhanced_active && sprite_active)
            sel_colour = sec_colour;             // Sprites only in enhanced
        else
            sel_colour = prim_colour;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register, one pixel per clock
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_out <= '0;
            g_out <= '0;
            b_out <= '0;
        end else begin
            r_out <= sel_colour[colour_pkg::red_lsb +: colour_pkg::nibble_bits];
            g_out <= sel_colour[colour_pkg::green_lsb +: colour_pkg::nibble_bits];
            b_out <= sel_colour[colour_pkg::blue_lsb +: colour_pkg::nibble_bits];
        end
    end

    // Cleared palettes keep the output defined from the first pixel on
    assert property (@(posedge clk_sys) reset |=> !$isunknown({r_out, g_out, b_out}))
        else $error("RGB output unknown after reset");

endmodule

/* design/gx4000_palette_top.sv */
module gx4000_palette_top (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic [asic_map_pkg::addr_bits-1:0]  cpu_addr,
    input  logic [asic_map_pkg::data_bits-1:0]  cpu_data,
    input  logic                                cpu_wr,
    input  logic                                plus_mode,
    input  logic [colour_pkg::index_bits-1:0]   pixel_index,
    input  logic                                sprite_active,  // From sprite engine
    input  logic [colour_pkg::index_bits-1:0]   sprite_pixel,
    output logic [colour_pkg::nibble_bits-1:0]  r_out,
    output logic [colour_pkg::nibble_bits-1:0]  g_out,
    output logic [colour_pkg::nibble_bits-1:0]  b_out
);

    // Write broadcast
    logic [colour_pkg::index_bits-1:0]  wr_index;
    logic                               prim_g_we;
    logic                               prim_rb_we;
    logic                               sec_we;
    logic [colour_pkg::colour_bits-1:0] sec_colour;
    logic [asic_map_pkg::data_bits-1:0] wr_byte;

    logic plus_active;
    logic enhanced_active;

    // All entries flattened, entry 0 in the low bits
    logic [colour_pkg::num_entries*colour_pkg::colour_bits-1:0] primary_colours;
    logic [colour_pkg::num_entries*colour_pkg::colour_bits-1:0] secondary_colours;

    asic_reg_decoder decoder_i (
        .clk_sys(clk_sys), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_wr(cpu_wr), .plus_mode(plus_mode),
        .wr_index(wr_index), .prim_g_we(prim_g_we), .prim_rb_we(prim_rb_we),
        .sec_we(sec_we), .sec_colour(sec_colour), .wr_byte(wr_byte),
        .plus_active(plus_active), .enhanced_active(enhanced_active)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Palette storage
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < colour_pkg::num_entries; i++) begin : g_entry
        palette_entry #(.entry_index(i)) entry_i (
            .clk_sys(clk_sys), .reset(reset), .wr_index(wr_index),
            .prim_g_we(prim_g_we), .prim_rb_we(prim_rb_we), .sec_we(sec_we),
            .sec_colour(sec_colour), .wr_byte(wr_byte),
            .primary_colour(primary_colours[i*colour_pkg::colour_bits +: colour_pkg::colour_bits]),
            .secondary_colour(secondary_colours[i*colour_pkg::colour_bits +: colour_pkg::colour_bits])
        );
    end

    pixel_colour_mux mux_i (
        .clk_sys(clk_sys), .reset(reset),
        .pixel_index(pixel_index), .sprite_active(sprite_active), .sprite_pixel(sprite_pixel),
        .plus_active(plus_active), .enhanced_active(enhanced_active),
        .primary_colours(primary_colours), .secondary_colours(secondary_colours),
        .r_out(r_out), .g_out(g_out), .b_out(b_out)
    );

endmodule

/* test/palette_tb.sv */
module palette_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // One table row, either a CPU write or a pixel with its expected colour
    typedef struct packed {
        logic                               is_pixel;
        logic [asic_map_pkg::addr_bits-1:0] addr;
        logic [asic_map_pkg::data_bits-1:0] data;
        logic                               plus;
        logic [colour_pkg::index_bits-1:0]  pix;
        logic                               spr;
        logic [colour_pkg::index_bits-1:0]  spr_pix;
        logic [colour_pkg::colour_bits-1:0] expected;    // {red, green, blue}
    } row_t;

    logic                               clk_sys;
    logic                               reset;
    logic [asic_map_pkg::addr_bits-1:0] cpu_addr;
    logic [asic_map_pkg::data_bits-1:0] cpu_data;
    logic                               cpu_wr;
    logic                               plus_mode;
    logic [colour_pkg::index_bits-1:0]  pixel_index;
    logic                               sprite_active;
    logic [colour_pkg::index_bits-1:0]  sprite_pixel;
    logic [colour_pkg::nibble_bits-1:0] r_out;
    logic [colour_pkg::nibble_bits-1:0] g_out;
    logic [colour_pkg::nibble_bits-1:0] b_out;

    row_t rows[$];                                   // Stimulus table
    int   timeout_cycles = 40;
    int   cycle_count    = 0;

    // Reference model state
    logic [11:0] prim_model [32];
    logic [11:0] sec_model  [32];
    logic [4:0]  ptr_model;
    logic [7:0]  latch_model;                        // Red upper, green lower
    logic [4:0]  mode_model;
    logic        plus_model;

    gx4000_palette_top dut_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;              // 125 MHz
    end

    //////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare
    //////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rgb(input string name, input logic [colour_pkg::nibble_bits-1:0] got,
                             input logic [colour_pkg::nibble_bits-1:0] expected);
        if (got !== expected)
            report_failure($sformatf("FAIL time=%0t %s got %h expected %h",
                                     $time, name, got, expected));
    endtask

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles)
            report_failure($sformatf("run timed out after %0d cycles", cycle_count));
    end

    //////////////////////////////////////////////////////////////////////////
    // Table builder, steps the model row by row
    //////////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] mrer_byte(input logic plus, input logic sel,
                                             input logic [4:0] mode);
        asic_map_pkg::asic_byte_u b;
        b.mrer_fields.plus = plus;
        b.mrer_fields.rom  = 1'b0;
        b.mrer_fields.sel  = sel;                    // Set means not an MRER write
        b.mrer_fields.mode = mode;
        return b;
    endfunction

    function automatic logic [7:0] rg_byte(input logic [3:0] red, input logic [3:0] green);
        asic_map_pkg::asic_byte_u b;
        b.rg_nibbles.red   = red;
        b.rg_nibbles.green = green;
        return b;
    endfunction

    function automatic logic enhanced_code(input logic [4:0] mode);
        return mode inside {5'h01, 5'h02, 5'h03, 5'h04, 5'h0C};
    endfunction

    task automatic add_write(input logic [15:0] addr, input logic [7:0] data);
        row_t row;
        row = '0;
        row.addr = addr;
        row.data = data;
        if (addr >= 16'h6400 && addr <= 16'h643F) begin
            if (addr[0])                             // Odd byte is red and blue
                prim_model[addr[5:1]] = {data[7:4], prim_model[addr[5:1]][7:4], data[3:0]};
            else
                prim_model[addr[5:1]][7:4] = data[3:0];
        end else if (addr == 16'h7F88) begin
            ptr_model = data[4:0];
        end else if (addr == 16'h7F89) begin
            latch_model = data;
        end else if (addr == 16'h7F8A) begin
            sec_model[ptr_model] = {latch_model, data[7:4]};
            ptr_model = ptr_model + 5'd1;            // Next entry
        end else if (addr == 16'h7F8C && !data[5]) begin
            mode_model = data[4:0];
            plus_model = data[7];
        end
        rows.push_back(row);
    endtask

    task automatic add_pixel(input logic [4:0] pix, input logic spr,
                             input logic [4:0] spr_pix, input logic plus);
        row_t       row;
        logic [4:0] eff;
        row = '0;
        row.is_pixel = 1'b1;
        row.plus     = plus;
        row.pix      = pix;
        row.spr      = spr;
        row.spr_pix  = spr_pix;
        eff = spr ? spr_pix : pix;
        if (plus || plus_model)
            row.expected = sec_model[eff];
        else if ((plus || enhanced_code(mode_model)) && spr)
            row.expected = sec_model[eff];           // Sprite in enhanced mode
        else
            row.expected = prim_model[eff & 5'd15];
        rows.push_back(row);
    endtask

    task automatic build_table();
        for (int i = 0; i < 32; i++) begin
            prim_model[i] = '0;
            sec_model[i]  = '0;
        end
        ptr_model   = '0;
        latch_model = '0;
        mode_model  = '0;
        plus_model  = 1'b0;
        // Black everywhere after reset
        for (int i = 0; i < 32; i++)
            add_pixel(5'(i), 1'b0, '0, 1'b0);
        add_pixel(5'd7, 1'b0, '0, 1'b1);
        add_pixel(5'd3, 1'b1, 5'd25, 1'b0);
        // Primary entries 4 and 10, green first
        add_write(16'h6408, 8'($urandom()));
        add_write(16'h6409, 8'($urandom()));
        add_write(16'h6414, 8'($urandom()));
        add_write(16'h6415, 8'($urandom()));
        add_pixel(5'd4, 1'b0, '0, 1'b0);
        add_pixel(5'd20, 1'b0, '0, 1'b0);            // Masked onto entry 4
        add_pixel(5'd10, 1'b0, '0, 1'b0);
        // Secondary entries 9 and 10 through the pointer
        add_write(asic_map_pkg::sec_pointer_addr, 8'd9);
        add_write(asic_map_pkg::sec_rg_addr, rg_byte(4'($urandom()), 4'($urandom())));
        add_write(asic_map_pkg::sec_b_addr, 8'($urandom()));
        add_write(asic_map_pkg::sec_rg_addr, rg_byte(4'($urandom()), 4'($urandom())));
        add_write(asic_map_pkg::sec_b_addr, 8'($urandom()));
        add_pixel(5'd9, 1'b0, '0, 1'b0);             // Still primary
        add_write(asic_map_pkg::mrer_addr, mrer_byte(1'b1, 1'b0, 5'h00));
        add_pixel(5'd9, 1'b0, '0, 1'b0);
        add_pixel(5'd10, 1'b0, '0, 1'b0);
        add_pixel(5'd4, 1'b0, '0, 1'b0);
        // Mode 02h splits sprite and background
        add_write(asic_map_pkg::mrer_addr, mrer_byte(1'b0, 1'b0, 5'h02));
        add_pixel(5'd4, 1'b1, 5'd10, 1'b0);
        add_pixel(5'd4, 1'b0, 5'd10, 1'b0);
        add_pixel(5'd10, 1'b0, '0, 1'b0);
        // Mode 05h is standard
        add_write(asic_map_pkg::mrer_addr, mrer_byte(1'b0, 1'b0, 5'h05));
        add_pixel(5'd4, 1'b1, 5'd10, 1'b0);
        add_pixel(5'd0, 1'b1, 5'd9, 1'b0);
        // Plus input with MRER clear
        add_write(asic_map_pkg::mrer_addr, mrer_byte(1'b0, 1'b0, 5'h00));
        add_pixel(5'd9, 1'b0, '0, 1'b1);
        add_pixel(5'd10, 1'b0, '0, 1'b1);
        add_pixel(5'd9, 1'b0, '0, 1'b0);
        // Ignored writes
        add_write(asic_map_pkg::mrer_addr, mrer_byte(1'b1, 1'b1, 5'h02));
        add_write(16'h7F8B, 8'($urandom()));
        add_write(16'h6440, 8'($urandom()));
        add_write(16'h63FF, 8'($urandom()));
        add_pixel(5'd9, 1'b0, '0, 1'b0);
        add_pixel(5'd4, 1'b1, 5'd10, 1'b0);
        add_pixel(5'd0, 1'b0, '0, 1'b0);
        // Pointer must have kept its place at 11
        add_write(asic_map_pkg::sec_rg_addr, rg_byte(4'($urandom()), 4'($urandom())));
        add_write(asic_map_pkg::sec_b_addr, 8'($urandom()));
        add_pixel(5'd11, 1'b0, '0, 1'b1);
        add_pixel(5'd0, 1'b1, 5'd11, 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Apply the table
    //////////////////////////////////////////////////////////////////////////

    task automatic drive_row(input row_t row);
        cpu_addr      = row.addr;
        cpu_data      = row.data;
        cpu_wr        = !row.is_pixel;
        plus_mode     = row.plus;
        pixel_index   = row.pix;
        sprite_active = row.spr;
        sprite_pixel  = row.spr_pix;
    endtask

    task automatic check_pixel(input row_t row);
        check_rgb("r_out", r_out, row.expected[11:8]);
        check_rgb("g_out", g_out, row.expected[7:4]);
        check_rgb("b_out", b_out, row.expected[3:0]);
    endtask

    initial begin
        drive_row('0);
        reset = 1'b1;
        void'($urandom(32'h76fc_4c58));
        build_table();
        timeout_cycles = rows.size() * 4 + 40;
        repeat (10) @(negedge clk_sys);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk_sys);
            if (i > 0 && rows[i-1].is_pixel)
                check_pixel(rows[i-1]);              // Presented one cycle ago
            drive_row(rows[i]);
        end
        @(negedge clk_sys);
        if (rows[rows.size()-1].is_pixel)
            check_pixel(rows[rows.size()-1]);
        drive_row('0);
        $display("all tests passed");
        $finish;
    end

endmodule

/* all.f */
design/colour_pkg.sv
design/asic_map_pkg.sv
design/asic_reg_decoder.sv
design/palette_entry.sv
design/pixel_colour_mux.sv
design/gx4000_palette_top.sv
test/palette_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the palette testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module palette_tb -Mdir obj_dir -f all.f &&
./obj_dir/Vpalette_tb || {
    echo "simulation build or run failed"
    exit 1
}
